// File: Bender.yml
package:
  name: frame_buf_reg

sources:
  - files:
      - rtl/frame_buf_reg_pkg.sv
      - rtl/frame_buf_apb_slave.sv
      - rtl/stream_ctrl_regs.sv
      - rtl/payload_size_regs.sv
      - rtl/frame_buf_reg_top.sv
  - target: test
    files:
      - dv/frame_buf_tb_clk.sv
      - dv/frame_buf_reg_checker.sv
      - dv/frame_buf_reg_tb.sv

// File: dv/frame_buf_reg_checker.sv
/*
 * Concurrent APB and output assertions for the register top level.
 * Bound into frame_buf_reg_top. Failures count up in assert_fails,
 * which the testbench reads at the end of the run.
 */
`timescale 1ns/100ps

module frame_buf_reg_checker import frame_buf_reg_pkg::*; (
	input logic              clk_frame_buf,
	input logic              i_rst_n,
	input logic              i_psel,
	input logic              i_penable,
	input logic              i_pready,
	input logic              i_pslverr,
	input depth_t            i_depth,
	input logic [REG_WD-1:0] i_payload_size,
	input logic              i_wr_stb,
	input reg_addr_t         i_addr,
	input short_reg_t        i_wdata
);

	int unsigned assert_fails = 0;
	logic        commit_wr;
	logic        addr_unmapped;

	// write of 1 in bit 0 to cfg done
	assign commit_wr = i_wr_stb && (i_addr == ADDR_CFG_DONE) && i_wdata[0];

	// register map as the apb master sees it
	assign addr_unmapped = !(i_addr inside {ADDR_CFG_DONE, ADDR_STREAM_EN, ADDR_PAYLOAD_HI,
		ADDR_PAYLOAD_LO, ADDR_BUF_DEPTH, ADDR_CHUNK_MODE});

	// --------------------------------------------------
	// apb handshake
	// --------------------------------------------------
	// pready in every access phase that follows a setup phase, and nowhere else
	pready_in_access: assert property (@(posedge clk_frame_buf) disable iff (!i_rst_n)
		i_pready == (i_psel && i_penable && $past(i_psel && !i_penable)))
		else begin
			assert_fails++;
			$error("pready outside an access phase");
		end

	// error response only for an unmapped address in the access phase
	pslverr_with_pready: assert property (@(posedge clk_frame_buf) disable iff (!i_rst_n)
		i_pslverr == (i_pready && addr_unmapped))
		else begin
			assert_fails++;
			$error("pslverr without pready");
		end

	// --------------------------------------------------
	// register outputs
	// --------------------------------------------------
	depth_in_range: assert property (@(posedge clk_frame_buf) disable iff (!i_rst_n)
		(short_reg_t'(i_depth) >= BUF_DEPTH_MIN) && (short_reg_t'(i_depth) <= BUF_DEPTH_MAX))
		else begin
			assert_fails++;
			$error("buffer depth left the 2..8 window");
		end

	// commit at E0, pulse, live loads at E1, seen changed at E2
	payload_after_commit: assert property (@(posedge clk_frame_buf) disable iff (!i_rst_n)
		$changed(i_payload_size) |-> $past(commit_wr, 2))
		else begin
			assert_fails++;
			$error("live payload changed without a commit write");
		end

endmodule

bind frame_buf_reg_top frame_buf_reg_checker u_checker (
	.clk_frame_buf  (clk_frame_buf),
	.i_rst_n        (i_rst_n),
	.i_psel         (i_psel),
	.i_penable      (i_penable),
	.i_pready       (o_pready),
	.i_pslverr      (o_pslverr),
	.i_depth        (ov_frame_buffer_depth),
	.i_payload_size (ov_payload_size),
	.i_wr_stb       (wr_stb),
	.i_addr         (bank_addr),
	.i_wdata        (bank_wdata)
);

// File: dv/frame_buf_reg_tb.sv
/*
 * Testbench for the frame buffer register list.
 * An APB driver runs directed and random accesses, a register model gives
 * the expected read data and outputs, a compare process checks each access.
 */
`timescale 1ns/100ps

module frame_buf_reg_tb import frame_buf_reg_pkg::*; ();

	// about 280 accesses planned, 40 cycles each at most
	localparam int unsigned N_ACCESSES     = 280;
	localparam int unsigned TIMEOUT_CYCLES = 40 * N_ACCESSES;
	localparam reg_addr_t   MAPPED_ADDRS [6] = '{ADDR_CFG_DONE, ADDR_STREAM_EN,
		ADDR_PAYLOAD_HI, ADDR_PAYLOAD_LO, ADDR_BUF_DEPTH, ADDR_CHUNK_MODE};

	logic              clk_frame_buf;
	logic              rst_n;
	logic              i_psel;
	logic              i_penable;
	logic              i_pwrite;
	reg_addr_t         i_paddr;
	short_reg_t        i_pwdata;
	short_reg_t        o_prdata;
	logic              o_pready;
	logic              o_pslverr;
	logic              o_stream_enable;
	logic              o_chunk_mode_active;
	depth_t            ov_frame_buffer_depth;
	logic [REG_WD-1:0] ov_payload_size;

	// register model starting at the reset values
	logic       m_en = 1'b0;
	logic       m_chunk = 1'b0;
	depth_t     m_depth = RST_BUF_DEPTH;
	short_reg_t m_hi_staged = RST_PAYLOAD_HI;
	short_reg_t m_lo_staged = RST_PAYLOAD_LO;
	short_reg_t m_hi_live = RST_PAYLOAD_HI;
	short_reg_t m_lo_live = RST_PAYLOAD_LO;
	logic       commit_pending = 1'b0;

	// observed and expected values of one access
	short_reg_t got_rdata, exp_rdata;
	logic       got_err, exp_err, got_en, got_chunk;
	depth_t     got_depth;
	logic [REG_WD-1:0] got_payload;
	int unsigned cycle_count = 0;
	event        access_done;

	frame_buf_tb_clk u_clk (
		.o_clk   (clk_frame_buf),
		.o_rst_n (rst_n)
	);

	frame_buf_reg_top dut (
		.clk_frame_buf         (clk_frame_buf),
		.i_rst_n               (rst_n),
		.i_psel                (i_psel),
		.i_penable             (i_penable),
		.i_pwrite              (i_pwrite),
		.i_paddr               (i_paddr),
		.i_pwdata              (i_pwdata),
		.o_prdata              (o_prdata),
		.o_pready              (o_pready),
		.o_pslverr             (o_pslverr),
		.o_stream_enable       (o_stream_enable),
		.o_chunk_mode_active   (o_chunk_mode_active),
		.ov_frame_buffer_depth (ov_frame_buffer_depth),
		.ov_payload_size       (ov_payload_size)
	);

	// --------------------------------------------------
	// register model
	// --------------------------------------------------
	function automatic logic addr_is_mapped(input reg_addr_t addr);
		return addr inside {ADDR_CFG_DONE, ADDR_STREAM_EN, ADDR_PAYLOAD_HI,
			ADDR_PAYLOAD_LO, ADDR_BUF_DEPTH, ADDR_CHUNK_MODE};
	endfunction

	// expected read data and error for one address
	function automatic void ref_read(input reg_addr_t addr, output short_reg_t data,
			output logic err);
		err = !addr_is_mapped(addr);
		case (addr)
			ADDR_STREAM_EN:  data = short_reg_t'(m_en);
			ADDR_CHUNK_MODE: data = short_reg_t'(m_chunk);
			ADDR_BUF_DEPTH:  data = short_reg_t'(m_depth);
			ADDR_PAYLOAD_HI: data = m_hi_staged;
			ADDR_PAYLOAD_LO: data = m_lo_staged;
			default:         data = '0;
		endcase
	endfunction

	function automatic void model_write(input reg_addr_t addr, input short_reg_t data);
		case (addr)
			ADDR_STREAM_EN:  m_en = data[0];
			ADDR_CHUNK_MODE: m_chunk = data[0];
			ADDR_BUF_DEPTH: begin
				if ((data >= BUF_DEPTH_MIN) && (data <= BUF_DEPTH_MAX)) begin
					m_depth = depth_t'(data);
				end
			end
			ADDR_PAYLOAD_HI: m_hi_staged = data;
			ADDR_PAYLOAD_LO: m_lo_staged = data;
			// live copy moves two edges later
			ADDR_CFG_DONE:   commit_pending = data[0];
			default: begin
			end
		endcase
	endfunction

	function automatic reg_addr_t pick_unmapped_addr();
		reg_addr_t addr;
		do begin
			addr = reg_addr_t'($urandom);
		end while (addr_is_mapped(addr));
		return addr;
	endfunction

	// --------------------------------------------------
	// apb driver, inputs change on the falling edge
	// --------------------------------------------------
	task automatic apb_access(input logic wr, input reg_addr_t addr, input short_reg_t wdata);
		short_reg_t ref_data;
		logic       ref_err;
		ref_read(addr, ref_data, ref_err);
		@(negedge clk_frame_buf);
		// an earlier commit has reached the live pair by now
		if (commit_pending) begin
			m_hi_live      = m_hi_staged;
			m_lo_live      = m_lo_staged;
			commit_pending = 1'b0;
		end
		i_psel    = 1'b1;
		i_penable = 1'b0;
		i_pwrite  = wr;
		i_paddr   = addr;
		i_pwdata  = wdata;
		@(negedge clk_frame_buf);
		i_penable = 1'b1;
		// sample a quarter period later
		#1;
		while (!o_pready) begin
			@(negedge clk_frame_buf);
			#1;
		end
		got_rdata = o_prdata;
		got_err   = o_pslverr;
		exp_rdata = wr ? '0 : ref_data;
		exp_err   = ref_err;
		@(negedge clk_frame_buf);
		i_psel    = 1'b0;
		i_penable = 1'b0;
		i_pwrite  = 1'b0;
		if (wr) begin
			model_write(addr, wdata);
		end
		#1;
		got_en      = o_stream_enable;
		got_chunk   = o_chunk_mode_active;
		got_depth   = ov_frame_buffer_depth;
		got_payload = ov_payload_size;
		-> access_done;
	endtask

	task automatic read_all_mapped();
		foreach (MAPPED_ADDRS[i]) begin
			apb_access(1'b0, MAPPED_ADDRS[i], '0);
		end
	endtask

	// --------------------------------------------------
	// compare tasks and compare process
	// --------------------------------------------------
	task automatic report_mismatch(input string msg);
		$display("Fail at %0t: %s", $time, msg);
		$display("CHECKS FAILED");
		$fatal(1, "stopping at the first mismatch");
	endtask

	task automatic check_short(input string what, input short_reg_t got, input short_reg_t exp);
		if (got !== exp) report_mismatch($sformatf("%s 0x%h, expected 0x%h", what, got, exp));
	endtask

	task automatic check_depth(input string what, input depth_t got, input depth_t exp);
		if (got !== exp) report_mismatch($sformatf("%s %0d, expected %0d", what, got, exp));
	endtask

	task automatic check_payload(input string what, input logic [REG_WD-1:0] got,
			input logic [REG_WD-1:0] exp);
		if (got !== exp) report_mismatch($sformatf("%s 0x%h, expected 0x%h", what, got, exp));
	endtask

	task automatic check_bit(input string what, input logic got, input logic exp);
		if (got !== exp) report_mismatch($sformatf("%s %b, expected %b", what, got, exp));
	endtask

	always @(access_done) begin
		check_short("prdata", got_rdata, exp_rdata);
		check_bit("pslverr", got_err, exp_err);
		check_bit("stream enable", got_en, m_en);
		check_bit("chunk mode", got_chunk, m_chunk);
		check_depth("buffer depth", got_depth, m_depth);
		check_payload("payload size", got_payload, {m_hi_live, m_lo_live});
	end

	// watchdog
	always @(posedge clk_frame_buf) begin
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("CHECKS FAILED");
			$fatal(1, "timeout");
		end
	end

	// --------------------------------------------------
	// stimulus
	// --------------------------------------------------
	initial begin
		reg_addr_t  addr;
		short_reg_t wdata;
		void'($urandom(32'hbe85_561e));
		i_psel    = 1'b0;
		i_penable = 1'b0;
		i_pwrite  = 1'b0;
		i_paddr   = '0;
		i_pwdata  = '0;
		wait (rst_n === 1'b1);
		// reset values
		read_all_mapped();
		// enable and chunk mode, cfg done reads zero
		apb_access(1'b1, ADDR_STREAM_EN, 16'h0001);
		apb_access(1'b1, ADDR_CHUNK_MODE, 16'hfff1);
		apb_access(1'b0, ADDR_STREAM_EN, '0);
		apb_access(1'b0, ADDR_CHUNK_MODE, '0);
		apb_access(1'b1, ADDR_STREAM_EN, 16'h0000);
		apb_access(1'b0, ADDR_CFG_DONE, '0);
		// depth range rule
		repeat (20) begin
			apb_access(1'b1, ADDR_BUF_DEPTH, short_reg_t'($urandom_range(15, 0)));
			apb_access(1'b0, ADDR_BUF_DEPTH, '0);
		end
		// staged payload, no commit with bit 0 clear, then commit
		apb_access(1'b1, ADDR_PAYLOAD_HI, short_reg_t'($urandom));
		apb_access(1'b1, ADDR_PAYLOAD_LO, short_reg_t'($urandom));
		apb_access(1'b0, ADDR_PAYLOAD_HI, '0);
		apb_access(1'b1, ADDR_CFG_DONE, 16'h0002);
		apb_access(1'b0, ADDR_PAYLOAD_LO, '0);
		apb_access(1'b1, ADDR_CFG_DONE, 16'h0001);
		apb_access(1'b0, ADDR_PAYLOAD_HI, '0);
		apb_access(1'b0, ADDR_PAYLOAD_LO, '0);
		// unmapped addresses
		repeat (10) begin
			apb_access(1'($urandom_range(1, 0)), pick_unmapped_addr(), short_reg_t'($urandom));
		end
		read_all_mapped();
		// random mix with small depth data so some writes land
		repeat (200) begin
			if ($urandom_range(9, 0) == 0) begin
				addr = pick_unmapped_addr();
			end else begin
				addr = MAPPED_ADDRS[$urandom_range(5, 0)];
			end
			wdata = (addr == ADDR_BUF_DEPTH) ? short_reg_t'($urandom_range(15, 0))
				: short_reg_t'($urandom);
			apb_access(1'($urandom_range(1, 0)), addr, wdata);
		end
		// lets a last commit reach the live pair
		apb_access(1'b0, ADDR_PAYLOAD_HI, '0);
		// compare process runs on the last access first
		@(negedge clk_frame_buf);
		if (dut.u_checker.assert_fails == 0) begin
			$display("ALL CHECKS PASSED");
			$finish;
		end else begin
			$display("CHECKS FAILED");
			$fatal(1, "concurrent assertion failures");
		end
	end

endmodule

// File: dv/frame_buf_tb_clk.sv
/*
 * Clock and reset source for the frame buffer register testbench.
 * 4 ns clock, active low reset held for 4 cycles and released on a
 * falling edge.
 */
`timescale 1ns/100ps

module frame_buf_tb_clk (
	output logic o_clk,
	output logic o_rst_n
);

	initial begin
		o_clk   = 1'b0;
		o_rst_n = 1'b0;
		// release away from the rising edge
		repeat (4) @(posedge o_clk);
		@(negedge o_clk);
		o_rst_n = 1'b1;
	end

	always #2 o_clk = ~o_clk;

endmodule

// File: rtl/frame_buf_apb_slave.sv
/*
 * APB3 slave front end for the frame buffer registers.
 * Finds the access phase, strobes writes into both banks and merges the
 * banks' read results into prdata. Zero wait state, pslverr when no bank
 * claims the address.
 */
`timescale 1ns/100ps

module frame_buf_apb_slave import frame_buf_reg_pkg::*; (
	input  logic       clk_frame_buf,
	input  logic       i_rst_n,
	// apb side
	input  logic       i_psel,
	input  logic       i_penable,
	input  logic       i_pwrite,
	input  reg_addr_t  i_paddr,
	input  short_reg_t i_pwdata,
	output short_reg_t o_prdata,
	output logic       o_pready,
	output logic       o_pslverr,
	// bank side
	output logic       o_wr_stb,
	output reg_addr_t  o_addr,
	output short_reg_t o_wdata,
	input  logic       i_stream_rd_hit,
	input  short_reg_t i_stream_rd_data,
	input  logic       i_payload_rd_hit,
	input  short_reg_t i_payload_rd_data
);

	// --------------------------------------------------
	// phase tracking
	// --------------------------------------------------
	logic       setup_seen;
	logic       access_phase;
	logic       any_hit;
	short_reg_t merged_rd_data;

	// set after a setup phase, so the next cycle may be the access phase
	// a held penable does not give a second access
	always_ff @(posedge clk_frame_buf or negedge i_rst_n) begin
		if (!i_rst_n) begin
			setup_seen <= 1'b0;
		end else begin
			setup_seen <= i_psel & ~i_penable;
		end
	end

	// psel and penable high, right after setup
	assign access_phase = i_psel & i_penable & setup_seen;

	// zero wait state, every access ends here
	assign o_pready = access_phase;

	// --------------------------------------------------
	// write path to the banks
	// --------------------------------------------------
	// address and data are stable from setup on
	assign o_addr   = i_paddr;
	assign o_wdata  = i_pwdata;
	// one cycle, banks sample it at the edge ending the access
	assign o_wr_stb = access_phase & i_pwrite;

	// --------------------------------------------------
	// read merge and error
	// --------------------------------------------------
	assign any_hit = i_stream_rd_hit | i_payload_rd_hit;

	// register sets of the banks do not overlap
	always_comb begin
		if (i_stream_rd_hit) begin
			merged_rd_data = i_stream_rd_data;
		end else if (i_payload_rd_hit) begin
			merged_rd_data = i_payload_rd_data;
		end else begin
			merged_rd_data = '0;
		end
	end

	// data only during a read access, zero otherwise
	assign o_prdata = (access_phase & ~i_pwrite) ? merged_rd_data : '0;

	// unclaimed address, reads and writes alike
	// an unclaimed write lands in no bank, so nothing changes
	assign o_pslverr = access_phase & ~any_hit;

endmodule

// File: rtl/frame_buf_reg_pkg.sv
/*
 * Shared register map of the frame buffer register list.
 * Holds address, width and reset constants plus the logic vector types
 * used by the APB slave, both register banks and the testbench.
 * Modules pull it in by a wildcard import in their header.
 */

package frame_buf_reg_pkg;

	// --------------------------------------------------
	// widths
	// --------------------------------------------------
	// one apb address per register, no byte scaling
	localparam int unsigned REG_ADDR_WD  = 9;
	// apb data and every register slot
	localparam int unsigned SHORT_REG_WD = 16;
	// combined payload size, hi half then lo half
	localparam int unsigned REG_WD       = 32;
	// depth field, 4 bits so that 8 fits
	localparam int unsigned BUF_DEPTH_WD = 4;

	// --------------------------------------------------
	// types
	// --------------------------------------------------
	typedef logic [REG_ADDR_WD-1:0]  reg_addr_t;
	typedef logic [SHORT_REG_WD-1:0] short_reg_t;
	typedef logic [BUF_DEPTH_WD-1:0] depth_t;

	// legal depth window, writes outside are dropped
	localparam short_reg_t BUF_DEPTH_MIN = 16'd2;
	localparam short_reg_t BUF_DEPTH_MAX = 16'd8;

	// --------------------------------------------------
	// register map
	// --------------------------------------------------
	// write only, bit 0 commits staged payload size
	localparam reg_addr_t ADDR_CFG_DONE   = 9'h020;
	localparam reg_addr_t ADDR_STREAM_EN  = 9'h030;
	localparam reg_addr_t ADDR_PAYLOAD_HI = 9'h037;
	localparam reg_addr_t ADDR_PAYLOAD_LO = 9'h038;
	localparam reg_addr_t ADDR_BUF_DEPTH  = 9'h044;
	localparam reg_addr_t ADDR_CHUNK_MODE = 9'h0a0;

	// reset values, payload is 0x004c_e300 at power up
	localparam short_reg_t RST_PAYLOAD_HI = 16'h004c;
	localparam short_reg_t RST_PAYLOAD_LO = 16'he300;
	localparam depth_t     RST_BUF_DEPTH  = 4'd2;

endpackage

// File: rtl/frame_buf_reg_top.sv
/*
 * Top level of the frame buffer register list.
 * Joins the APB slave to the stream control and payload size banks.
 * Everything runs on clk_frame_buf.
 */
`timescale 1ns/100ps

module frame_buf_reg_top import frame_buf_reg_pkg::*; (
	input  logic              clk_frame_buf,
	input  logic              i_rst_n,
	// apb3 slave port
	input  logic              i_psel,
	input  logic              i_penable,
	input  logic              i_pwrite,
	input  reg_addr_t         i_paddr,
	input  short_reg_t        i_pwdata,
	output short_reg_t        o_prdata,
	output logic              o_pready,
	output logic              o_pslverr,
	// register outputs
	output logic              o_stream_enable,
	output logic              o_chunk_mode_active,
	output depth_t            ov_frame_buffer_depth,
	output logic [REG_WD-1:0] ov_payload_size
);

	// --------------------------------------------------
	// slave to bank wiring
	// --------------------------------------------------
	logic       wr_stb;
	reg_addr_t  bank_addr;
	short_reg_t bank_wdata;
	logic       stream_rd_hit;
	short_reg_t stream_rd_data;
	logic       payload_rd_hit;
	short_reg_t payload_rd_data;

	frame_buf_apb_slave u_apb_slave (
		.clk_frame_buf     (clk_frame_buf),
		.i_rst_n           (i_rst_n),
		.i_psel            (i_psel),
		.i_penable         (i_penable),
		.i_pwrite          (i_pwrite),
		.i_paddr           (i_paddr),
		.i_pwdata          (i_pwdata),
		.o_prdata          (o_prdata),
		.o_pready          (o_pready),
		.o_pslverr         (o_pslverr),
		.o_wr_stb          (wr_stb),
		.o_addr            (bank_addr),
		.o_wdata           (bank_wdata),
		.i_stream_rd_hit   (stream_rd_hit),
		.i_stream_rd_data  (stream_rd_data),
		.i_payload_rd_hit  (payload_rd_hit),
		.i_payload_rd_data (payload_rd_data)
	);

	// enable, chunk mode, depth
	stream_ctrl_regs u_stream_ctrl_regs (
		.clk_frame_buf         (clk_frame_buf),
		.i_rst_n               (i_rst_n),
		.i_wr_stb              (wr_stb),
		.i_addr                (bank_addr),
		.i_wdata               (bank_wdata),
		.o_rd_hit              (stream_rd_hit),
		.o_rd_data             (stream_rd_data),
		.o_stream_enable       (o_stream_enable),
		.o_chunk_mode_active   (o_chunk_mode_active),
		.ov_frame_buffer_depth (ov_frame_buffer_depth)
	);

	// staged and live payload size
	payload_size_regs u_payload_size_regs (
		.clk_frame_buf   (clk_frame_buf),
		.i_rst_n         (i_rst_n),
		.i_wr_stb        (wr_stb),
		.i_addr          (bank_addr),
		.i_wdata         (bank_wdata),
		.o_rd_hit        (payload_rd_hit),
		.o_rd_data       (payload_rd_data),
		.ov_payload_size (ov_payload_size)
	);

endmodule

// File: rtl/payload_size_regs.sv
/*
 * Payload size register bank.
 * Two staged 16-bit halves are written and read back over APB. A write of
 * 1 in bit 0 of the config done register fires a one cycle commit pulse,
 * and the live pair takes the staged halves on the following edge.
 */
`timescale 1ns/100ps

module payload_size_regs import frame_buf_reg_pkg::*; (
	input  logic              clk_frame_buf,
	input  logic              i_rst_n,
	input  logic              i_wr_stb,
	input  reg_addr_t         i_addr,
	input  short_reg_t        i_wdata,
	output logic              o_rd_hit,
	output short_reg_t        o_rd_data,
	output logic [REG_WD-1:0] ov_payload_size
);

	short_reg_t payload_hi_staged;
	short_reg_t payload_lo_staged;
	short_reg_t payload_hi_live;
	short_reg_t payload_lo_live;
	logic       commit_pulse;

	// --------------------------------------------------
	// staged halves and commit pulse
	// --------------------------------------------------
	always_ff @(posedge clk_frame_buf or negedge i_rst_n) begin
		if (!i_rst_n) begin
			payload_hi_staged <= RST_PAYLOAD_HI;
			payload_lo_staged <= RST_PAYLOAD_LO;
			commit_pulse      <= 1'b0;
		end else begin
			// self clearing, high for the cycle after the commit write
			commit_pulse <= i_wr_stb && (i_addr == ADDR_CFG_DONE) && i_wdata[0];
			if (i_wr_stb && (i_addr == ADDR_PAYLOAD_HI)) begin
				payload_hi_staged <= i_wdata;
			end
			if (i_wr_stb && (i_addr == ADDR_PAYLOAD_LO)) begin
				payload_lo_staged <= i_wdata;
			end
		end
	end

	// --------------------------------------------------
	// live copy
	// --------------------------------------------------
	// both halves move together, never a torn pair
	always_ff @(posedge clk_frame_buf or negedge i_rst_n) begin
		if (!i_rst_n) begin
			payload_hi_live <= RST_PAYLOAD_HI;
			payload_lo_live <= RST_PAYLOAD_LO;
		end else if (commit_pulse) begin
			payload_hi_live <= payload_hi_staged;
			payload_lo_live <= payload_lo_staged;
		end
	end

	assign ov_payload_size = {payload_hi_live, payload_lo_live};

	// --------------------------------------------------
	// read side
	// --------------------------------------------------
	// readback shows the staged values, cfg done reads as zero
	always_comb begin
		o_rd_hit  = 1'b1;
		o_rd_data = '0;
		case (i_addr)
			ADDR_PAYLOAD_HI: o_rd_data = payload_hi_staged;
			ADDR_PAYLOAD_LO: o_rd_data = payload_lo_staged;
			ADDR_CFG_DONE:   o_rd_data = '0;
			default:         o_rd_hit  = 1'b0;
		endcase
	end

endmodule

// File: rtl/stream_ctrl_regs.sv
/*
 * Stream control register bank.
 * Holds stream enable, chunk mode and the frame buffer depth. Depth
 * writes outside 2..8 are dropped. Read data and hit are combinational
 * from the address.
 */
`timescale 1ns/100ps

module stream_ctrl_regs import frame_buf_reg_pkg::*; (
	input  logic       clk_frame_buf,
	input  logic       i_rst_n,
	input  logic       i_wr_stb,
	input  reg_addr_t  i_addr,
	input  short_reg_t i_wdata,
	output logic       o_rd_hit,
	output short_reg_t o_rd_data,
	output logic       o_stream_enable,
	output logic       o_chunk_mode_active,
	output depth_t     ov_frame_buffer_depth
);

	logic   stream_enable;
	logic   chunk_mode_active;
	depth_t frame_buffer_depth;
	logic   depth_in_range;

	// --------------------------------------------------
	// write side
	// --------------------------------------------------
	// check the whole write word, not just the low nibble
	assign depth_in_range = (i_wdata >= BUF_DEPTH_MIN) && (i_wdata <= BUF_DEPTH_MAX);

	always_ff @(posedge clk_frame_buf or negedge i_rst_n) begin
		if (!i_rst_n) begin
			stream_enable      <= 1'b0;
			chunk_mode_active  <= 1'b0;
			frame_buffer_depth <= RST_BUF_DEPTH;
		end else if (i_wr_stb) begin
			case (i_addr)
				ADDR_STREAM_EN: begin
					stream_enable <= i_wdata[0];
				end
				ADDR_CHUNK_MODE: begin
					chunk_mode_active <= i_wdata[0];
				end
				ADDR_BUF_DEPTH: begin
					// out of range keeps the old depth
					if (depth_in_range) begin
						frame_buffer_depth <= i_wdata[BUF_DEPTH_WD-1:0];
					end
				end
				default: begin
				end
			endcase
		end
	end

	// --------------------------------------------------
	// read side
	// --------------------------------------------------
	// hit is address only, writes claim it too
	always_comb begin
		o_rd_hit  = 1'b1;
		o_rd_data = '0;
		case (i_addr)
			ADDR_STREAM_EN:  o_rd_data = {{(SHORT_REG_WD-1){1'b0}}, stream_enable};
			ADDR_CHUNK_MODE: o_rd_data = {{(SHORT_REG_WD-1){1'b0}}, chunk_mode_active};
			ADDR_BUF_DEPTH: begin
				o_rd_data = {{(SHORT_REG_WD-BUF_DEPTH_WD){1'b0}}, frame_buffer_depth};
			end
			default:         o_rd_hit = 1'b0;
		endcase
	end

	// outputs straight from the flops
	assign o_stream_enable       = stream_enable;
	assign o_chunk_mode_active   = chunk_mode_active;
	assign ov_frame_buffer_depth = frame_buffer_depth;

endmodule

// File: tb.f
rtl/frame_buf_reg_pkg.sv
rtl/frame_buf_apb_slave.sv
rtl/stream_ctrl_regs.sv
rtl/payload_size_regs.sv
rtl/frame_buf_reg_top.sv
dv/frame_buf_tb_clk.sv
dv/frame_buf_reg_checker.sv
dv/frame_buf_reg_tb.sv
